/* common/cnn_pkg.sv */
package cnn_pkg;

	// ------------------------------------------------------------
	// Bus and pixel sizes
	// ------------------------------------------------------------
	localparam int W_ADDR       = 32;
	localparam int W_DATA       = 32;
	localparam int W_PIX        = 8;
	localparam int PIX_PER_WORD = 4;   // Packed pixels per bus word

	// Image geometry limits
	localparam int MAX_WIDTH  = 16;
	localparam int MAX_HEIGHT = 16;
	localparam int W_SIZE     = 5;     // Row, col, width and height fields
	localparam int BUF_DEPTH  = MAX_WIDTH * MAX_HEIGHT;
	localparam int W_BUF_ADDR = 8;

	// 3x3 window, tap 0 top-left, tap 8 bottom-right
	localparam int N_TAPS   = 9;
	localparam int W_WINDOW = N_TAPS * W_PIX;

	// ------------------------------------------------------------
	// Register map, word index from HADDR[4:2]
	// ------------------------------------------------------------
	localparam int W_REG_SEL = 3;
	localparam logic [W_REG_SEL-1:0] REG_WIDTH_HEIGHT = 3'd0;
	localparam logic [W_REG_SEL-1:0] REG_IMAGE_BASE   = 3'd1;
	localparam logic [W_REG_SEL-1:0] REG_IMAGE_LOAD   = 3'd2;
	localparam logic [W_REG_SEL-1:0] REG_LAYER_START  = 3'd3;
	localparam logic [W_REG_SEL-1:0] REG_LAYER_DONE   = 3'd4;

	// AHB encodings
	localparam logic [1:0] TRANS_IDLE   = 2'b00;
	localparam logic [1:0] TRANS_NONSEQ = 2'b10;
	localparam logic [1:0] TRANS_SEQ    = 2'b11;
	localparam logic       RESP_OKAY    = 1'b0;

	// DMA line FSM
	localparam logic [1:0] ST_IDLE      = 2'd0;
	localparam logic [1:0] ST_LINE_LOAD = 2'd1;   // Issuing address phases
	localparam logic [1:0] ST_LINE_WAIT = 2'd2;   // Draining last data phase
	localparam logic [1:0] ST_DONE      = 2'd3;

endpackage

/* src/ahb_cfg_regs.sv */
`timescale 1ns/10ps

module ahb_cfg_regs import cnn_pkg::*; (
	input  logic              clk,
	input  logic              rstn,
	input  logic              sl_hsel_i,
	input  logic              sl_hready_i,
	input  logic [1:0]        sl_htrans_i,
	input  logic              sl_hwrite_i,
	input  logic [W_ADDR-1:0] sl_haddr_i,
	input  logic [W_DATA-1:0] sl_hwdata_i,
	input  logic              load_done_i,    // Status from DMA
	input  logic              layer_done_i,   // Status from scanner
	output logic              sl_hready_o,
	output logic              sl_hresp_o,
	output logic [W_DATA-1:0] sl_hrdata_o,
	output logic [W_SIZE-1:0] width_o,
	output logic [W_SIZE-1:0] height_o,
	output logic [W_ADDR-1:0] image_base_o,
	output logic              load_start_o,
	output logic              layer_start_o
);

	logic [W_REG_SEL-1:0] sel_q;   // Index captured in address phase
	logic                 wr_q;    // Write pending in data phase
	logic                 addr_ok;
	logic [W_SIZE-1:0]    width_q;
	logic [W_SIZE-1:0]    height_q;
	logic [W_ADDR-1:0]    base_q;
	logic                 load_start_q;
	logic                 layer_start_q;

	// Zero wait, always OKAY
	assign sl_hready_o = 1'b1;
	assign sl_hresp_o  = RESP_OKAY;

	assign addr_ok = sl_hsel_i && sl_hready_i &&
		(sl_htrans_i == TRANS_NONSEQ || sl_htrans_i == TRANS_SEQ);

	//------------------------------------------------------------
	// Address phase
	//------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			sel_q <= '0;
			wr_q  <= 1'b0;
		end else if (addr_ok) begin
			sel_q <= sl_haddr_i[W_REG_SEL+1:2];   // Word index
			wr_q  <= sl_hwrite_i;
		end else begin
			wr_q  <= 1'b0;
		end
	end

	//------------------------------------------------------------
	// Data phase, register update and start pulses
	//------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			width_q       <= W_SIZE'(MAX_WIDTH);
			height_q      <= W_SIZE'(MAX_HEIGHT);
			base_q        <= '0;
			load_start_q  <= 1'b0;
			layer_start_q <= 1'b0;
		end else begin
			// Pulses last one cycle by default
			load_start_q  <= 1'b0;
			layer_start_q <= 1'b0;
			if (wr_q) begin
				case (sel_q)
					REG_WIDTH_HEIGHT: begin
						width_q  <= sl_hwdata_i[W_SIZE-1:0];
						height_q <= sl_hwdata_i[16 +: W_SIZE];
					end
					REG_IMAGE_BASE:  base_q        <= sl_hwdata_i;
					REG_IMAGE_LOAD:  load_start_q  <= sl_hwdata_i[0];
					REG_LAYER_START: layer_start_q <= sl_hwdata_i[0];
					default: ;   // Status and unused words ignore writes
				endcase
			end
		end
	end

	assign width_o       = width_q;
	assign height_o      = height_q;
	assign image_base_o  = base_q;
	assign load_start_o  = load_start_q;
	assign layer_start_o = layer_start_q;

	// Readback mux on captured index
	always_comb begin
		sl_hrdata_o = '0;
		case (sel_q)
			REG_WIDTH_HEIGHT: begin
				sl_hrdata_o[W_SIZE-1:0]   = width_q;
				sl_hrdata_o[16 +: W_SIZE] = height_q;
			end
			REG_IMAGE_BASE: sl_hrdata_o    = base_q;
			REG_IMAGE_LOAD: sl_hrdata_o[0] = load_done_i;
			REG_LAYER_DONE: sl_hrdata_o[0] = layer_done_i;
			default:        sl_hrdata_o    = '0;   // LAYER_START reads 0 too
		endcase
	end

	// Software never issues back-to-back start writes
	a_load_pulse: assert property (@(posedge clk) disable iff (!rstn)
		load_start_o |=> !load_start_o);
	a_layer_pulse: assert property (@(posedge clk) disable iff (!rstn)
		layer_start_o |=> !layer_start_o);

endmodule

/* dma/image_dma.sv */
`timescale 1ns/10ps

module image_dma import cnn_pkg::*; (
	input  logic              clk,
	input  logic              rstn,
	input  logic              load_start_i,
	input  logic [W_SIZE-1:0] width_i,
	input  logic [W_SIZE-1:0] height_i,
	input  logic [W_ADDR-1:0] image_base_i,
	input  logic              m_hready_i,
	input  logic [W_DATA-1:0] m_hrdata_i,
	output logic [1:0]        m_htrans_o,
	output logic [W_ADDR-1:0] m_haddr_o,
	output logic              m_hwrite_o,
	output logic [2:0]        m_hsize_o,
	output logic [2:0]        m_hburst_o,
	output logic [W_DATA-1:0] m_hwdata_o,
	output logic [W_DATA-1:0] word_o,
	output logic              word_vld_o,
	output logic              load_done_o
);

	logic [1:0]        state_q;
	logic [W_SIZE-1:0] line_cnt_q;       // Line being fetched
	logic [W_ADDR-1:0] line_addr_q;      // Byte address of line start
	logic [W_SIZE-1:0] word_cnt_q;       // Address phases issued in line
	logic              dphase_q;         // Data phase outstanding
	logic              word_vld_q;
	logic              load_done_q;
	logic [W_SIZE-1:0] words_per_line;
	logic              addr_acc;         // Address phase taken
	logic              data_acc;         // Data phase completes

	assign words_per_line = width_i >> $clog2(PIX_PER_WORD);
	assign addr_acc       = (state_q == ST_LINE_LOAD) && m_hready_i;
	assign data_acc       = dphase_q && m_hready_i;

	//------------------------------------------------------------
	// Master outputs, single word reads only
	//------------------------------------------------------------
	assign m_htrans_o = (state_q == ST_LINE_LOAD) ? TRANS_NONSEQ : TRANS_IDLE;
	assign m_haddr_o  = line_addr_q + W_ADDR'(word_cnt_q) * (W_DATA / 8);
	assign m_hwrite_o = 1'b0;
	assign m_hsize_o  = 3'b010;   // Word
	assign m_hburst_o = 3'b000;   // SINGLE
	assign m_hwdata_o = '0;

	//------------------------------------------------------------
	// Line FSM
	//------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q     <= ST_IDLE;
			line_cnt_q  <= '0;
			line_addr_q <= '0;
			word_cnt_q  <= '0;
			dphase_q    <= 1'b0;
			word_vld_q  <= 1'b0;
			load_done_q <= 1'b0;
		end else begin
			// Data phase follows an accepted address phase
			if (m_hready_i)
				dphase_q <= addr_acc;
			word_vld_q <= data_acc;
			case (state_q)
				ST_IDLE, ST_DONE: begin
					state_q <= ST_IDLE;
					if (load_start_i) begin
						state_q     <= ST_LINE_LOAD;
						line_cnt_q  <= '0;
						line_addr_q <= image_base_i;
						word_cnt_q  <= '0;
						load_done_q <= 1'b0;
					end
				end
				ST_LINE_LOAD: begin
					if (addr_acc) begin
						word_cnt_q <= word_cnt_q + 1'b1;
						if (word_cnt_q == words_per_line - 1'b1)
							state_q <= ST_LINE_WAIT;   // Last address of line
					end
				end
				ST_LINE_WAIT: begin
					// No overlap across lines, wait for the last word
					if (data_acc) begin
						word_cnt_q <= '0;
						if (line_cnt_q == height_i - 1'b1) begin
							state_q     <= ST_DONE;
							load_done_q <= 1'b1;
						end else begin
							state_q     <= ST_LINE_LOAD;
							line_cnt_q  <= line_cnt_q + 1'b1;
							line_addr_q <= line_addr_q + W_ADDR'(width_i);   // One byte per pixel
						end
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// Read data capture
	always_ff @(posedge clk) begin
		if (data_acc)
			word_o <= m_hrdata_i;
	end

	assign word_vld_o  = word_vld_q;
	assign load_done_o = load_done_q;

	a_no_seq: assert property (@(posedge clk) disable iff (!rstn)
		m_htrans_o != TRANS_SEQ);
	// Stalled address phase holds
	a_addr_hold: assert property (@(posedge clk) disable iff (!rstn)
		(m_htrans_o == TRANS_NONSEQ && !m_hready_i) |=>
		(m_htrans_o == TRANS_NONSEQ && $stable(m_haddr_o)));

endmodule

/* src/image_buf.sv */
`timescale 1ns/10ps

module image_buf import cnn_pkg::*; (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  load_start_i,
	input  logic [W_DATA-1:0]     word_i,
	input  logic                  word_vld_i,
	input  logic [W_SIZE-1:0]     width_i,
	input  logic [W_BUF_ADDR-1:0] pix_addr_i,   // Window centre
	input  logic                  first_row_i,
	input  logic                  last_row_i,
	input  logic                  first_col_i,
	input  logic                  last_col_i,
	output logic [W_WINDOW-1:0]   taps_o
);

	logic [W_PIX-1:0]      mem [BUF_DEPTH];
	logic [W_BUF_ADDR:0]   wr_ptr_q;        // Extra bit shows overrun
	logic [W_BUF_ADDR-1:0] row_base [3];    // Centre column of rows above, at, below
	logic [2:0]            row_ok;
	logic [2:0]            col_ok;

	//------------------------------------------------------------
	// Write side, four pixels per word
	//------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			wr_ptr_q <= '0;
		else if (load_start_i)
			wr_ptr_q <= '0;   // New frame
		else if (word_vld_i)
			wr_ptr_q <= wr_ptr_q + (W_BUF_ADDR+1)'(PIX_PER_WORD);
	end

	always_ff @(posedge clk) begin
		if (word_vld_i) begin
			// Low byte is the lowest pixel index
			for (int i = 0; i < PIX_PER_WORD; i++)
				mem[wr_ptr_q[W_BUF_ADDR-1:0] + W_BUF_ADDR'(i)] <= word_i[i*W_PIX +: W_PIX];
		end
	end

	//------------------------------------------------------------
	// Window taps
	//------------------------------------------------------------
	assign row_base[0] = pix_addr_i - W_BUF_ADDR'(width_i);
	assign row_base[1] = pix_addr_i;
	assign row_base[2] = pix_addr_i + W_BUF_ADDR'(width_i);

	// Bit 0 is the left/top neighbour, bit 2 the right/bottom one
	assign row_ok = {!last_row_i, 1'b1, !first_row_i};
	assign col_ok = {!last_col_i, 1'b1, !first_col_i};

	always_comb begin
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				if (row_ok[r] && col_ok[c])
					taps_o[(r*3+c)*W_PIX +: W_PIX] = mem[row_base[r] + W_BUF_ADDR'(c) - 1'b1];
				else
					taps_o[(r*3+c)*W_PIX +: W_PIX] = '0;   // Zero padding
			end
		end
	end

	// DMA must not run past the buffer
	a_ptr_range: assert property (@(posedge clk) disable iff (!rstn)
		word_vld_i |-> (wr_ptr_q <= BUF_DEPTH - PIX_PER_WORD));

endmodule

/* src/frame_scan.sv */
`timescale 1ns/10ps

module frame_scan import cnn_pkg::*; (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  layer_start_i,
	input  logic [W_SIZE-1:0]     width_i,
	input  logic [W_SIZE-1:0]     height_i,
	input  logic [W_WINDOW-1:0]   taps_i,
	output logic [W_BUF_ADDR-1:0] pix_addr_o,
	output logic                  first_row_o,
	output logic                  last_row_o,
	output logic                  first_col_o,
	output logic                  last_col_o,
	output logic [W_WINDOW-1:0]   out_window_o,
	output logic                  out_valid_o,
	output logic                  layer_done_o
);

	logic                  run_q;
	logic [W_SIZE-1:0]     row_q;
	logic [W_SIZE-1:0]     col_q;
	logic [W_BUF_ADDR-1:0] addr_q;   // Row-major pixel index
	logic                  valid_q;
	logic                  last_q;   // Output holds the final pixel
	logic                  done_q;
	logic                  first_row;
	logic                  last_row;
	logic                  first_col;
	logic                  last_col;

	// Boundary flags
	assign first_row = (row_q == '0);
	assign last_row  = (row_q == height_i - 1'b1);
	assign first_col = (col_q == '0);
	assign last_col  = (col_q == width_i - 1'b1);

	//------------------------------------------------------------
	// Pixel walk
	//------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			run_q  <= 1'b0;
			row_q  <= '0;
			col_q  <= '0;
			addr_q <= '0;
		end else if (layer_start_i) begin
			run_q  <= 1'b1;
			row_q  <= '0;
			col_q  <= '0;
			addr_q <= '0;
		end else if (run_q) begin
			addr_q <= addr_q + 1'b1;
			if (last_col) begin
				col_q <= '0;
				if (last_row)
					run_q <= 1'b0;   // Frame finished
				else
					row_q <= row_q + 1'b1;
			end else begin
				col_q <= col_q + 1'b1;
			end
		end
	end

	//------------------------------------------------------------
	// Output stage and done flag
	//------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			valid_q <= 1'b0;
			last_q  <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			valid_q <= run_q;
			last_q  <= run_q && last_row && last_col;
			if (layer_start_i)
				done_q <= 1'b0;
			else if (valid_q && last_q)
				done_q <= 1'b1;   // Cycle after last window
		end
	end

	always_ff @(posedge clk) begin
		out_window_o <= taps_i;
	end

	assign pix_addr_o   = addr_q;
	assign first_row_o  = first_row;
	assign last_row_o   = last_row;
	assign first_col_o  = first_col;
	assign last_col_o   = last_col;
	assign out_valid_o  = valid_q;
	assign layer_done_o = done_q;

	a_valid_done: assert property (@(posedge clk) disable iff (!rstn)
		!(out_valid_o && layer_done_o));

endmodule

/* src/cnn_accel.sv */
`timescale 1ns/10ps

module cnn_accel import cnn_pkg::*; (
	input  logic                clk,
	input  logic                rstn,
	// Control slave port
	input  logic                sl_hsel_i,
	input  logic                sl_hready_i,
	input  logic [1:0]          sl_htrans_i,
	input  logic                sl_hwrite_i,
	input  logic [W_ADDR-1:0]   sl_haddr_i,
	input  logic [W_DATA-1:0]   sl_hwdata_i,
	output logic                sl_hready_o,
	output logic                sl_hresp_o,
	output logic [W_DATA-1:0]   sl_hrdata_o,
	// Image master port
	input  logic                m_hready_i,
	input  logic                m_hresp_i,    // Errors not acted on
	input  logic [W_DATA-1:0]   m_hrdata_i,
	output logic [1:0]          m_htrans_o,
	output logic [W_ADDR-1:0]   m_haddr_o,
	output logic                m_hwrite_o,
	output logic [2:0]          m_hsize_o,
	output logic [2:0]          m_hburst_o,
	output logic [W_DATA-1:0]   m_hwdata_o,
	// Window stream
	output logic [W_WINDOW-1:0] out_window_o,
	output logic                out_valid_o
);

	logic [W_SIZE-1:0]     width;
	logic [W_SIZE-1:0]     height;
	logic [W_ADDR-1:0]     image_base;
	logic                  load_start;    // Pulse from IMAGE_LOAD write
	logic                  layer_start;   // Pulse from LAYER_START write
	logic                  load_done;
	logic                  layer_done;
	logic [W_DATA-1:0]     word;          // DMA word to buffer
	logic                  word_vld;
	logic [W_BUF_ADDR-1:0] pix_addr;      // Scan centre pixel
	logic                  first_row;
	logic                  last_row;
	logic                  first_col;
	logic                  last_col;
	logic [W_WINDOW-1:0]   taps;

	ahb_cfg_regs u_regs (
		.clk           (clk),
		.rstn          (rstn),
		.sl_hsel_i     (sl_hsel_i),
		.sl_hready_i   (sl_hready_i),
		.sl_htrans_i   (sl_htrans_i),
		.sl_hwrite_i   (sl_hwrite_i),
		.sl_haddr_i    (sl_haddr_i),
		.sl_hwdata_i   (sl_hwdata_i),
		.load_done_i   (load_done),
		.layer_done_i  (layer_done),
		.sl_hready_o   (sl_hready_o),
		.sl_hresp_o    (sl_hresp_o),
		.sl_hrdata_o   (sl_hrdata_o),
		.width_o       (width),
		.height_o      (height),
		.image_base_o  (image_base),
		.load_start_o  (load_start),
		.layer_start_o (layer_start)
	);

	image_dma u_dma (
		.clk          (clk),
		.rstn         (rstn),
		.load_start_i (load_start),
		.width_i      (width),
		.height_i     (height),
		.image_base_i (image_base),
		.m_hready_i   (m_hready_i),
		.m_hrdata_i   (m_hrdata_i),
		.m_htrans_o   (m_htrans_o),
		.m_haddr_o    (m_haddr_o),
		.m_hwrite_o   (m_hwrite_o),
		.m_hsize_o    (m_hsize_o),
		.m_hburst_o   (m_hburst_o),
		.m_hwdata_o   (m_hwdata_o),
		.word_o       (word),
		.word_vld_o   (word_vld),
		.load_done_o  (load_done)
	);

	image_buf u_buf (
		.clk          (clk),
		.rstn         (rstn),
		.load_start_i (load_start),
		.word_i       (word),
		.word_vld_i   (word_vld),
		.width_i      (width),
		.pix_addr_i   (pix_addr),
		.first_row_i  (first_row),
		.last_row_i   (last_row),
		.first_col_i  (first_col),
		.last_col_i   (last_col),
		.taps_o       (taps)
	);

	frame_scan u_scan (
		.clk           (clk),
		.rstn          (rstn),
		.layer_start_i (layer_start),
		.width_i       (width),
		.height_i      (height),
		.taps_i        (taps),
		.pix_addr_o    (pix_addr),
		.first_row_o   (first_row),
		.last_row_o    (last_row),
		.first_col_o   (first_col),
		.last_col_o    (last_col),
		.out_window_o  (out_window_o),
		.out_valid_o   (out_valid_o),
		.layer_done_o  (layer_done)
	);

endmodule

/* testbench/tb_cnn_accel.sv */
`timescale 1ns/10ps

module tb_cnn_accel import cnn_pkg::*; ();

	localparam int CLK_PERIOD   = 20;
	localparam int DRIVE_DLY    = 2;    // Input drive skew after rising edge
	localparam int RESET_CYCLES = 16;
	localparam int SEED         = 36;
	localparam int MAX_STALL    = 3;    // Worst HREADY low run per word
	localparam int STIM_WORDS   = 2 + BUF_DEPTH / PIX_PER_WORD;
	// Full frame load with stalls, two scans, register traffic margin
	localparam int TIMEOUT_CYCLES = RESET_CYCLES
		+ (BUF_DEPTH / PIX_PER_WORD) * (MAX_STALL + 2)
		+ 2 * (BUF_DEPTH + 20) + 300;
	localparam logic [W_ADDR-1:0] SLAVE_BASE = 32'h4000_0000;

	logic                clk;
	logic                rstn;
	logic                sl_hsel_i;
	logic                sl_hready_i;
	logic [1:0]          sl_htrans_i;
	logic                sl_hwrite_i;
	logic [W_ADDR-1:0]   sl_haddr_i;
	logic [W_DATA-1:0]   sl_hwdata_i;
	logic                sl_hready_o;
	logic                sl_hresp_o;
	logic [W_DATA-1:0]   sl_hrdata_o;
	logic                m_hready_i;
	logic                m_hresp_i;
	logic [W_DATA-1:0]   m_hrdata_i;
	logic [1:0]          m_htrans_o;
	logic [W_ADDR-1:0]   m_haddr_o;
	logic                m_hwrite_o;
	logic [2:0]          m_hsize_o;
	logic [2:0]          m_hburst_o;
	logic [W_DATA-1:0]   m_hwdata_o;
	logic [W_WINDOW-1:0] out_window_o;
	logic                out_valid_o;

	logic [W_DATA-1:0]   stim [STIM_WORDS];   // Geometry, base, packed image
	logic [W_PIX-1:0]    pixels [BUF_DEPTH];  // Unpacked reference image
	int                  img_w;
	int                  img_h;
	int                  npix;
	logic [W_ADDR-1:0]   img_base;
	int                  errors      = 0;
	int                  win_cnt     = 0;     // Windows seen in current scan
	int                  win_total   = 0;
	int                  words_taken = 0;     // Master address phases accepted
	logic                valid_prev  = 1'b0;

	cnn_accel DUT (.*);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	task automatic report_error(input string msg);
		errors++;
		$display("[FAIL] t=%0d ns %s", $time, msg);
	endtask

	// Address phase now, data phase next cycle, returns after data phase
	task automatic write_reg(input logic [W_REG_SEL-1:0] idx, input logic [W_DATA-1:0] data);
		sl_hsel_i   = 1'b1;
		sl_htrans_i = TRANS_NONSEQ;
		sl_hwrite_i = 1'b1;
		sl_haddr_i  = SLAVE_BASE | (W_ADDR'(idx) << 2);
		@(posedge clk);
		#DRIVE_DLY;
		sl_hsel_i   = 1'b0;
		sl_htrans_i = TRANS_IDLE;
		sl_hwrite_i = 1'b0;
		sl_hwdata_i = data;
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic read_reg(input logic [W_REG_SEL-1:0] idx, output logic [W_DATA-1:0] data);
		sl_hsel_i   = 1'b1;
		sl_htrans_i = TRANS_NONSEQ;
		sl_hwrite_i = 1'b0;
		sl_haddr_i  = SLAVE_BASE | (W_ADDR'(idx) << 2);
		@(posedge clk);
		#DRIVE_DLY;
		sl_hsel_i   = 1'b0;
		sl_htrans_i = TRANS_IDLE;
		data = sl_hrdata_o;   // Data phase, stable after the edge
		if (sl_hready_o !== 1'b1 || sl_hresp_o !== RESP_OKAY)
			report_error("slave data phase is not zero-wait OKAY");
	endtask

	// Zero-padded 3x3 neighbourhood, tap k in byte k, row-major taps
	function automatic logic [W_WINDOW-1:0] expected_window(input int p);
		int r;
		int c;
		int rr;
		int cc;
		logic [W_WINDOW-1:0] win;
		r = p / img_w;
		c = p % img_w;
		win = '0;
		for (int dr = -1; dr <= 1; dr++) begin
			for (int dc = -1; dc <= 1; dc++) begin
				rr = r + dr;
				cc = c + dc;
				if (rr >= 0 && rr < img_h && cc >= 0 && cc < img_w)
					win[((dr + 1) * 3 + dc + 1) * W_PIX +: W_PIX] = pixels[rr * img_w + cc];
			end
		end
		return win;
	endfunction

	function automatic logic [W_DATA-1:0] mem_word(input logic [W_ADDR-1:0] addr);
		int idx;
		idx = int'((addr - img_base) >> 2);
		if (addr >= img_base && idx < npix / PIX_PER_WORD)
			return stim[2 + idx];
		return addr ^ 32'h5A5A_A5A5;   // Outside the image
	endfunction

	// ------------------------------------------------------------
	// AHB memory model with random stalls
	// ------------------------------------------------------------
	initial begin : mem_model
		logic              take;
		logic [W_ADDR-1:0] a;
		logic              dp_active;
		logic [W_ADDR-1:0] dp_addr;
		int                stall_left;
		int unsigned       seed_draw;
		seed_draw  = $urandom(SEED);
		dp_active  = 1'b0;
		dp_addr    = '0;
		stall_left = 0;
		forever begin
			@(negedge clk);
			take = rstn && m_hready_i && (m_htrans_o != TRANS_IDLE);
			a    = m_haddr_o;
			if (rstn && m_htrans_o === TRANS_SEQ)
				report_error("master drove HTRANS SEQ");
			if (take) begin
				if (a !== img_base + 4 * words_taken)
					report_error($sformatf("word %0d address %h, expected %h",
						words_taken, a, img_base + 4 * words_taken));
				if (m_hwrite_o !== 1'b0)
					report_error("master issued a write");
				if (m_hsize_o !== 3'b010)   // Word transfer
					report_error($sformatf("word %0d HSIZE %b, expected 010",
						words_taken, m_hsize_o));
				if (m_hburst_o !== 3'b000)  // SINGLE
					report_error($sformatf("word %0d HBURST %b, expected 000",
						words_taken, m_hburst_o));
				if ($isunknown(m_hwdata_o))
					report_error("master left HWDATA undefined");
				words_taken++;
			end
			@(posedge clk);
			#DRIVE_DLY;
			if (m_hready_i)
				dp_active = 1'b0;   // Data phase ended at this edge
			if (take) begin
				dp_active  = 1'b1;
				dp_addr    = a;
				stall_left = $urandom % (MAX_STALL + 1);
			end
			if (dp_active && stall_left > 0) begin
				m_hready_i = 1'b0;
				m_hrdata_i = 'x;
				stall_left--;
			end else begin
				m_hready_i = 1'b1;
				m_hrdata_i = dp_active ? mem_word(dp_addr) : '0;
			end
		end
	end

	// Window checker, sampled mid-cycle
	always @(negedge clk) begin
		if (rstn && out_valid_o === 1'b1) begin
			if (!valid_prev && win_cnt != 0)
				report_error("out_valid_o restarted after a gap inside a frame");
			if (win_cnt >= npix)
				report_error("more valid windows than pixels");
			else if (out_window_o !== expected_window(win_cnt))
				report_error($sformatf("window %0d is %h, expected %h",
					win_cnt, out_window_o, expected_window(win_cnt)));
			win_cnt++;
			win_total++;
		end
		valid_prev = out_valid_o;
	end

	task automatic run_scan(input string tag);
		logic [W_DATA-1:0] rd;
		win_cnt = 0;
		write_reg(REG_LAYER_START, 32'd1);
		// Start pulse cycle, then two cycles of latency
		if (out_valid_o !== 1'b0)
			report_error($sformatf("%s out_valid_o high in the start pulse cycle", tag));
		@(posedge clk);
		#DRIVE_DLY;
		if (out_valid_o !== 1'b0)
			report_error($sformatf("%s out_valid_o high one cycle after start", tag));
		@(posedge clk);
		#DRIVE_DLY;
		if (out_valid_o !== 1'b1)
			report_error($sformatf("%s out_valid_o low two cycles after start", tag));
		read_reg(REG_LAYER_DONE, rd);
		if (rd !== 32'd0)
			report_error($sformatf("%s LAYER_DONE reads %h during the scan", tag, rd));
		while (out_valid_o === 1'b1) begin
			@(posedge clk);
			#DRIVE_DLY;
		end
		if (win_cnt != npix)
			report_error($sformatf("%s gave %0d windows, expected %0d", tag, win_cnt, npix));
		read_reg(REG_LAYER_DONE, rd);
		if (rd !== 32'd1)
			report_error($sformatf("%s LAYER_DONE reads %h after the frame", tag, rd));
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin : main_flow
		logic [W_DATA-1:0] rd;
		logic [W_DATA-1:0] exp_geom;
		rstn        = 1'b0;
		sl_hsel_i   = 1'b0;
		sl_hready_i = 1'b1;
		sl_htrans_i = TRANS_IDLE;
		sl_hwrite_i = 1'b0;
		sl_haddr_i  = '0;
		sl_hwdata_i = '0;
		m_hready_i  = 1'b1;
		m_hresp_i   = RESP_OKAY;
		m_hrdata_i  = '0;
		$readmemh("testbench/cnn_stim.hex", stim);
		img_w    = int'(stim[0][W_SIZE-1:0]);
		img_h    = int'(stim[0][16 +: W_SIZE]);
		img_base = stim[1];
		npix     = img_w * img_h;
		for (int i = 0; i < npix; i++)
			pixels[i] = stim[2 + i / PIX_PER_WORD][(i % PIX_PER_WORD) * W_PIX +: W_PIX];
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rstn = 1'b1;

		// Reset state
		if (out_valid_o !== 1'b0)
			report_error("out_valid_o high after reset");
		read_reg(REG_WIDTH_HEIGHT, rd);
		exp_geom = (W_DATA'(MAX_HEIGHT) << 16) | W_DATA'(MAX_WIDTH);
		if (rd !== exp_geom)
			report_error($sformatf("reset WIDTH_HEIGHT %h, expected %h", rd, exp_geom));
		read_reg(REG_IMAGE_LOAD, rd);
		if (rd !== 32'd0)
			report_error($sformatf("reset IMAGE_LOAD status %h, expected 0", rd));
		read_reg(REG_LAYER_DONE, rd);
		if (rd !== 32'd0)
			report_error($sformatf("reset LAYER_DONE %h, expected 0", rd));

		// Geometry and base readback
		write_reg(REG_WIDTH_HEIGHT, stim[0]);
		write_reg(REG_IMAGE_BASE, img_base);
		exp_geom = (W_DATA'(img_h) << 16) | W_DATA'(img_w);
		read_reg(REG_WIDTH_HEIGHT, rd);
		if (rd !== exp_geom)
			report_error($sformatf("WIDTH_HEIGHT %h, expected %h", rd, exp_geom));
		read_reg(REG_IMAGE_BASE, rd);
		if (rd !== img_base)
			report_error($sformatf("IMAGE_BASE %h, expected %h", rd, img_base));
		read_reg(REG_LAYER_START, rd);
		if (rd !== 32'd0)
			report_error($sformatf("LAYER_START reads %h, expected 0", rd));
		for (int i = 5; i < 8; i++) begin
			read_reg(W_REG_SEL'(i), rd);
			if (rd !== 32'd0)
				report_error($sformatf("unused index %0d reads %h", i, rd));
		end

		// Image load, poll until done
		write_reg(REG_IMAGE_LOAD, 32'd1);
		do
			read_reg(REG_IMAGE_LOAD, rd);
		while (rd[0] !== 1'b1);
		if (words_taken != npix / PIX_PER_WORD)
			report_error($sformatf("%0d words fetched, expected %0d",
				words_taken, npix / PIX_PER_WORD));

		run_scan("first scan");
		run_scan("second scan");   // Clears done and repeats the frame

		$display("Errors: %0d, windows checked: %0d, words fetched: %0d",
			errors, win_total, words_taken);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Run limit
	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* testbench/cnn_stim.hex */
// Word 0 is width in bits 4:0 and height in bits 20:16, word 1 the image byte base
// Then packed image words in row-major order, lowest byte holds the lowest pixel
00080008
00001040
0E0B0805
1A171411
2623201D
322F2C29
3E3B3835
4A474441
5653504D
625F5C59
6E6B6865
7A777471
8683807D
928F8C89
9E9B9895
AAA7A4A1
B6B3B0AD
C2BFBCB9

/* list.f */
common/cnn_pkg.sv
src/ahb_cfg_regs.sv
dma/image_dma.sv
src/image_buf.sv
src/frame_scan.sv
src/cnn_accel.sv
testbench/tb_cnn_accel.sv

/* Bender.yml */
package:
  name: cnn_accel

sources:
  - common/cnn_pkg.sv
  - src/ahb_cfg_regs.sv
  - dma/image_dma.sv
  - src/image_buf.sv
  - src/frame_scan.sv
  - src/cnn_accel.sv
  - target: test
    files:
      - testbench/tb_cnn_accel.sv
